//--- RiscvCore.f
source/RiscvPkg.sv
source/InstrFetch.sv
source/InstrDecoder.sv
source/Alu.sv
source/RegFile.sv
source/DataMem.sv
source/Controller.sv
source/RiscvCore.sv
sim/ClockGen.sv
sim/RiscvCore_props.sv
sim/RiscvCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the RiscvCore testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f RiscvCore.f --top-module RiscvCoreTb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/VRiscvCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

//--- sim/RiscvCoreTb.sv
`timescale 1ns/100ps

module RiscvCoreTb;
    import RiscvPkg::*;

    localparam int ResetCycles = 8;
    localparam int ProgramWords = 83; // all test programs together.
    localparam int CycleLimit = ProgramWords * 4 + ResetCycles + ProgramWords;
    localparam logic [6:0] ImmOp = 7'b0010011;
    localparam logic [6:0] LoadOp = 7'b0000011;
    localparam logic [6:0] JalrOp = 7'b1100111;
    localparam logic [31:0] EbreakWord = 32'h0010_0073;

    logic       clk;
    logic       reset;
    logic       start;
    logic       halted;
    progWrite_t progWrite;
    retire_t    retire;

    logic [31:0] prog [$];
    retire_t     expQ [$];
    retire_t     gotQ [$];
    int          errors;
    int          testErrors;
    int          cycleCount;
    int          seed;

    ClockGen clockGen_i (
        .clk   (clk),
        .reset (reset)
    );

    RiscvCore dut_i (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .progWrite (progWrite),
        .retire    (retire),
        .halted    (halted)
    );

    bind RiscvCore RiscvCore_props props_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .halted (halted),
        .retire (retire)
    );

    function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jType(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] uType(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // rv32i result of an op or op-imm instruction.
    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:
            begin
                if (alt)
                    return $signed(a) >>> sh;
                else
                    return a >> sh;
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic countError();
        errors++;
        testErrors++;
    endtask

    task automatic expectRetire(logic [31:0] pc, logic we, logic [4:0] rd, logic [31:0] data);
        retire_t r;
        r.valid          = 1'b1;
        r.pc             = pc;
        r.regWriteEnable = we;
        r.rd             = rd;
        r.regWriteData   = data;
        expQ.push_back(r);
    endtask

    // instruction that is expected to retire where it sits.
    task automatic addInstr(logic [31:0] word, logic we, logic [4:0] rd, logic [31:0] data);
        expectRetire(32'(prog.size() * 4), we, rd, data);
        prog.push_back(word);
    endtask

    task automatic loadConst(logic [4:0] rd, logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + {19'b0, value[11]}; // addi sign-extends the low part.
        addInstr(uType(upper, rd), 1'b1, rd, {upper, 12'b0});
        addInstr(iType(value[11:0], rd, 3'd0, rd, ImmOp), 1'b1, rd, value);
    endtask

    task automatic beginTest();
        prog.delete();
        expQ.delete();
        gotQ.delete();
    endtask

    task automatic checkRetires();
        int n;
        n = (gotQ.size() < expQ.size()) ? gotQ.size() : expQ.size();
        assert (gotQ.size() == expQ.size())
        else
        begin
            $display("wrong number of retired instructions: expected %0d, got %0d",
                     expQ.size(), gotQ.size());
            countError();
        end
        for (int i = 0; i < n; i++)
        begin
            assert (gotQ[i].pc == expQ[i].pc)
            else
            begin
                $display("FAILED retire.pc: expected %h, got %h", expQ[i].pc, gotQ[i].pc);
                countError();
            end
            assert (gotQ[i].regWriteEnable == expQ[i].regWriteEnable)
            else
            begin
                $display("FAILED retire.regWriteEnable at pc %h: expected %h, got %h",
                         expQ[i].pc, expQ[i].regWriteEnable, gotQ[i].regWriteEnable);
                countError();
            end
            if (expQ[i].regWriteEnable)
            begin
                assert (gotQ[i].rd == expQ[i].rd && gotQ[i].regWriteData == expQ[i].regWriteData)
                else
                begin
                    $display("FAILED retire.regWriteData at pc %h: expected x%0d=%h, got x%0d=%h",
                             expQ[i].pc, expQ[i].rd, expQ[i].regWriteData,
                             gotQ[i].rd, gotQ[i].regWriteData);
                    countError();
                end
            end
        end
    endtask

    // load, start, collect retires until halted, then compare.
    task automatic runProgram();
        logic done;
        foreach (prog[i])
        begin
            @(posedge clk);
            #2;
            progWrite.valid = 1'b1;
            progWrite.addr  = ImemIndexWidth'(i);
            progWrite.data  = prog[i];
        end
        @(posedge clk);
        #2;
        progWrite.valid = 1'b0;
        start = 1'b1;
        @(posedge clk);
        #2 start = 1'b0;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            if (retire.valid)
                gotQ.push_back(retire);
            done = halted;
        end
        checkRetires();
    endtask

    task automatic finishTest(string name);
        $display("test %s done with %0d errors", name, testErrors);
        testErrors = 0;
    endtask

    task automatic aluTest();
        logic [3:0]  ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
        logic [31:0] r1;
        logic [31:0] r2;
        logic [11:0] imm;
        logic [4:0]  rd;
        beginTest();
        r1 = $random(seed);
        r2 = $random(seed);
        loadConst(5'd1, r1);
        loadConst(5'd2, r2);
        for (int i = 0; i < 10; i++)
        begin
            rd = 5'(3 + i);
            addInstr(rType(ops[i][3] ? 7'h20 : 7'h00, 5'd2, 5'd1, ops[i][2:0], rd), 1'b1, rd,
                     aluRef(ops[i][2:0], ops[i][3], r1, r2));
        end
        for (int i = 0; i < 10; i++)
        begin
            if (i == 1)
                continue; // no subtract-immediate.
            rd  = 5'(13 + i);
            imm = 12'($random(seed));
            if (ops[i][1:0] == 2'b01)
                imm = {1'b0, ops[i][3], 5'b0, imm[4:0]}; // shifts take shamt and func7.
            addInstr(iType(imm, 5'd1, ops[i][2:0], rd, ImmOp), 1'b1, rd,
                     aluRef(ops[i][2:0], ops[i][3], r1, {{20{imm[11]}}, imm}));
        end
        addInstr(EbreakWord, 1'b0, 5'd0, 32'd0);
        runProgram();
        finishTest("alu");
    endtask

    task automatic memTest();
        logic [31:0] r;
        logic [31:0] m;
        beginTest();
        r = $random(seed);
        loadConst(5'd2, r);
        addInstr(iType(12'd64, 5'd0, 3'd0, 5'd1, ImmOp), 1'b1, 5'd1, 32'd64);
        addInstr(sType(12'd0, 5'd2, 5'd1, 3'd2), 1'b0, 5'd0, 32'd0);
        m = r;
        addInstr(iType(12'hfa5, 5'd0, 3'd0, 5'd5, ImmOp), 1'b1, 5'd5, 32'hffff_ffa5);
        addInstr(sType(12'd1, 5'd5, 5'd1, 3'd0), 1'b0, 5'd0, 32'd0);
        m[15:8] = 8'ha5;
        addInstr(sType(12'd2, 5'd5, 5'd1, 3'd1), 1'b0, 5'd0, 32'd0);
        m[31:16] = 16'hffa5;
        addInstr(iType(12'd0, 5'd1, 3'd2, 5'd6, LoadOp), 1'b1, 5'd6, m);
        addInstr(iType(12'd1, 5'd1, 3'd0, 5'd7, LoadOp), 1'b1, 5'd7, {{24{m[15]}}, m[15:8]});
        addInstr(iType(12'd1, 5'd1, 3'd4, 5'd8, LoadOp), 1'b1, 5'd8, {24'b0, m[15:8]});
        addInstr(iType(12'd2, 5'd1, 3'd1, 5'd9, LoadOp), 1'b1, 5'd9, {{16{m[31]}}, m[31:16]});
        addInstr(iType(12'd2, 5'd1, 3'd5, 5'd10, LoadOp), 1'b1, 5'd10, {16'b0, m[31:16]});
        addInstr(iType(12'd0, 5'd1, 3'd0, 5'd11, LoadOp), 1'b1, 5'd11, {{24{m[7]}}, m[7:0]});
        addInstr(iType(12'd0, 5'd1, 3'd5, 5'd12, LoadOp), 1'b1, 5'd12, {16'b0, m[15:0]});
        addInstr(EbreakWord, 1'b0, 5'd0, 32'd0);
        runProgram();
        finishTest("loads and stores");
    endtask

    task automatic branchTest();
        logic [2:0]  f3s [12] = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4,
                                   3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
        logic        swap [12] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
                                   1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
        logic        same [12] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0,
                                   1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] count;
        beginTest();
        addInstr(iType(12'hffb, 5'd0, 3'd0, 5'd1, ImmOp), 1'b1, 5'd1, 32'hffff_fffb);
        addInstr(iType(12'd3, 5'd0, 3'd0, 5'd2, ImmOp), 1'b1, 5'd2, 32'd3);
        addInstr(iType(12'd0, 5'd0, 3'd0, 5'd31, ImmOp), 1'b1, 5'd31, 32'd0);
        count = 0;
        for (int i = 0; i < 12; i++)
        begin
            rs1 = swap[i] ? 5'd2 : 5'd1;
            rs2 = (same[i] || swap[i]) ? 5'd1 : 5'd2;
            va  = (rs1 == 5'd1) ? 32'hffff_fffb : 32'd3;
            vb  = (rs2 == 5'd1) ? 32'hffff_fffb : 32'd3;
            pc  = 32'(prog.size() * 4);
            expectRetire(pc, 1'b0, 5'd0, 32'd0);
            prog.push_back(bType(13'd8, rs2, rs1, f3s[i]));
            prog.push_back(iType(12'd1, 5'd31, 3'd0, 5'd31, ImmOp)); // skipped when taken.
            if (!branchTaken(f3s[i], va, vb))
            begin
                count++;
                expectRetire(pc + 32'd4, 1'b1, 5'd31, count);
            end
        end
        addInstr(EbreakWord, 1'b0, 5'd0, 32'd0);
        runProgram();
        finishTest("branches");
    endtask

    task automatic jumpTest();
        beginTest();
        addInstr(jType(21'd12, 5'd1), 1'b1, 5'd1, 32'd4);
        prog.push_back(iType(12'd1, 5'd0, 3'd0, 5'd5, ImmOp));
        prog.push_back(iType(12'd1, 5'd0, 3'd0, 5'd5, ImmOp));
        addInstr(iType(12'd25, 5'd0, 3'd0, 5'd2, ImmOp), 1'b1, 5'd2, 32'd25);
        addInstr(iType(12'd0, 5'd2, 3'd0, 5'd3, JalrOp), 1'b1, 5'd3, 32'd20); // odd target.
        prog.push_back(iType(12'd1, 5'd0, 3'd0, 5'd5, ImmOp));
        addInstr(EbreakWord, 1'b0, 5'd0, 32'd0);
        runProgram();
        finishTest("jumps");
    endtask

    task automatic zeroRegTest();
        beginTest();
        addInstr(iType(12'd123, 5'd0, 3'd0, 5'd0, ImmOp), 1'b0, 5'd0, 32'd0);
        addInstr(iType(12'd7, 5'd0, 3'd0, 5'd2, ImmOp), 1'b1, 5'd2, 32'd7);
        addInstr(rType(7'h00, 5'd2, 5'd0, 3'd0, 5'd3), 1'b1, 5'd3, 32'd7);
        addInstr(rType(7'h00, 5'd0, 5'd0, 3'd0, 5'd4), 1'b1, 5'd4, 32'd0);
        addInstr(EbreakWord, 1'b0, 5'd0, 32'd0);
        runProgram();
        finishTest("x0");
    endtask

    task automatic haltTest();
        beginTest();
        addInstr(iType(12'd55, 5'd0, 3'd0, 5'd1, ImmOp), 1'b1, 5'd1, 32'd55);
        addInstr(EbreakWord, 1'b0, 5'd0, 32'd0);
        runProgram();
        repeat (4)
        begin
            @(negedge clk);
            assert (halted && !retire.valid)
            else
            begin
                $display("core left the halted state or retired after ebreak");
                countError();
            end
        end
        // a second program shows that loading works again.
        beginTest();
        addInstr(iType(12'd77, 5'd0, 3'd0, 5'd1, ImmOp), 1'b1, 5'd1, 32'd77);
        addInstr(EbreakWord, 1'b0, 5'd0, 32'd0);
        runProgram();
        finishTest("halt");
    endtask

    initial
    begin
        cycleCount = 0;
        while (cycleCount <= CycleLimit)
        begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CycleLimit);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        seed       = 32'h50a2_12bc;
        errors     = 0;
        testErrors = 0;
        start      = 1'b0;
        progWrite  = '0;
        wait (!reset);
        aluTest();
        memTest();
        branchTest();
        jumpTest();
        zeroRegTest();
        haltTest();
        $display("6 tests run, %0d errors, %0d cycles", errors, cycleCount);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- sim/RiscvCore_props.sv
`timescale 1ns/100ps

module RiscvCore_props (
    input logic              clk,
    input logic              reset,
    input logic              start,
    input logic              halted,
    input RiscvPkg::retire_t retire
);
    logic waitingStart;

    // high from reset until the first start pulse.
    always_ff @(posedge clk)
    begin
        if (reset)
            waitingStart <= 1'b1;
        else if (start)
            waitingStart <= 1'b0;
    end

    noWriteToX0: assert property (@(posedge clk) disable iff (reset)
        retire.valid && retire.regWriteEnable |-> retire.rd != '0)
        else $error("register write to x0 is visible on retire");

    quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !retire.valid)
        else $error("instruction retired while halted");

    quietBeforeStart: assert property (@(posedge clk) disable iff (reset)
        waitingStart |-> !retire.valid)
        else $error("instruction retired before start");

endmodule

//--- sim/ClockGen.sv
`timescale 1ns/100ps

module ClockGen (
    output logic clk,
    output logic reset
);
    localparam int HalfPeriodNs = 10;
    localparam int ResetCycles = 8;

    initial
    begin
        clk = 1'b0;
        forever #(HalfPeriodNs) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #2 reset = 1'b0; // released with the rest of the stimulus.
    end

endmodule

//--- source/RiscvCore.sv
`timescale 1ns/100ps

module RiscvCore (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  RiscvPkg::progWrite_t progWrite,
    output RiscvPkg::retire_t    retire,
    output logic                 halted
);
    import RiscvPkg::*;

    logic [AddrWidth-1:0] pc;
    logic [DataWidth-1:0] instr;
    logic [DataWidth-1:0] readData1;
    logic [DataWidth-1:0] readData2;
    logic [DataWidth-1:0] aluB;
    logic [DataWidth-1:0] aluO;
    logic [DataWidth-1:0] regWriteData;
    logic [DataWidth-1:0] pcWriteData;
    logic                 running;
    logic                 haltReq;
    logic                 regWriteEnable;
    logic                 pcWriteEnable;
    decoded_t             decoded;

    assign aluB = decoded.useImm ? decoded.imm : readData2;

    InstrFetch instrFetch_i (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .progWrite     (progWrite),
        .haltReq       (haltReq),
        .pcWriteEnable (pcWriteEnable),
        .pcWriteData   (pcWriteData),
        .pc            (pc),
        .instr         (instr),
        .running       (running),
        .halted        (halted)
    );

    InstrDecoder instrDecoder_i (
        .instr   (instr),
        .running (running),
        .decoded (decoded)
    );

    RegFile regFile_i (
        .clk         (clk),
        .reset       (reset),
        .readAddr1   (decoded.rs1),
        .readAddr2   (decoded.rs2),
        .readData1   (readData1),
        .readData2   (readData2),
        .writeEnable (regWriteEnable),
        .writeAddr   (decoded.rd),
        .writeData   (regWriteData)
    );

    Alu alu_i (
        .aluOp (decoded.aluOp),
        .a     (readData1),
        .b     (aluB),
        .aluO  (aluO)
    );

    // the store value is rs2.
    Controller controller_i (
        .clk            (clk),
        .reset          (reset),
        .decoded        (decoded),
        .readData1      (readData2),
        .aluO           (aluO),
        .pc             (pc),
        .regWriteEnable (regWriteEnable),
        .regWriteData   (regWriteData),
        .pcWriteEnable  (pcWriteEnable),
        .pcWriteData    (pcWriteData),
        .haltReq        (haltReq),
        .retire         (retire)
    );

endmodule

//--- source/Controller.sv
`timescale 1ns/100ps

module Controller (
    input  logic                           clk,
    input  logic                           reset,
    input  RiscvPkg::decoded_t             decoded,
    input  logic [RiscvPkg::DataWidth-1:0] readData1, // store data.
    input  logic [RiscvPkg::DataWidth-1:0] aluO,
    input  logic [RiscvPkg::AddrWidth-1:0] pc,
    output logic                           regWriteEnable,
    output logic [RiscvPkg::DataWidth-1:0] regWriteData,
    output logic                           pcWriteEnable,
    output logic [RiscvPkg::DataWidth-1:0] pcWriteData,
    output logic                           haltReq,
    output RiscvPkg::retire_t              retire
);
    import RiscvPkg::*;

    logic [AddrWidth-1:0] memAddr;
    logic [DataWidth-1:0] memReadData;
    logic [DataWidth-1:0] memWriteData;
    logic                 memWriteEnable;
    logic                 memWriteReq;
    logic                 rdWritable;

    assign rdWritable = decoded.rd != '0; // writes to x0 never show up.

    always_comb
    begin
        regWriteEnable = 1'b0;
        regWriteData   = '0;
        memWriteReq    = 1'b0;
        pcWriteEnable  = 1'b0;
        pcWriteData    = '0;
        haltReq        = 1'b0;
        case (decoded.state)
            RegWrite:
            begin
                regWriteEnable = rdWritable;
                regWriteData   = aluO;
            end
            MemReadRegWrite:
            begin
                regWriteEnable = rdWritable;
                regWriteData   = memReadData;
            end
            MemWrite:
                memWriteReq = 1'b1;
            PcSelectWrite:
            begin
                if (aluO != '0) // branch taken.
                begin
                    pcWriteEnable = 1'b1;
                    pcWriteData   = pc + decoded.imm;
                end
            end
            PcWrite:
            begin
                // jal is pc relative, jalr takes its target from the alu.
                pcWriteEnable  = 1'b1;
                pcWriteData    = (decoded.aluOp == JalrTarget) ? aluO : pc + decoded.imm;
                regWriteEnable = rdWritable;
                regWriteData   = pc + 4;
            end
            LuiRegWrite:
            begin
                regWriteEnable = rdWritable;
                regWriteData   = decoded.imm;
            end
            Halt:
                haltReq = 1'b1;
            default: ;
        endcase
    end

    assign memAddr        = aluO;
    assign memWriteData   = readData1;
    assign memWriteEnable = memWriteReq && !reset;

    assign retire.valid          = decoded.state != Idle;
    assign retire.pc             = pc;
    assign retire.regWriteEnable = regWriteEnable;
    assign retire.rd             = decoded.rd;
    assign retire.regWriteData   = regWriteData;

    DataMem dataMem_i (
        .clk            (clk),
        .memAddr        (memAddr),
        .memWriteEnable (memWriteEnable),
        .memWriteData   (memWriteData),
        .func3          (decoded.func3),
        .memReadData    (memReadData)
    );

endmodule

//--- source/DataMem.sv
`timescale 1ns/100ps

module DataMem (
    input  logic                           clk,
    input  logic [RiscvPkg::AddrWidth-1:0] memAddr,
    input  logic                           memWriteEnable,
    input  logic [RiscvPkg::DataWidth-1:0] memWriteData,
    input  logic [2:0]                     func3,
    output logic [RiscvPkg::DataWidth-1:0] memReadData
);
    import RiscvPkg::*;

    logic [DataWidth-1:0]      mem [DmemDepth];
    logic [DmemIndexWidth-1:0] index;
    logic [1:0]                offset;
    logic [DataWidth-1:0]      word;
    logic [7:0]                byteData;
    logic [15:0]               halfData;

    assign index    = memAddr[DmemIndexWidth+1:2];
    assign offset   = memAddr[1:0];
    assign word     = mem[index];
    assign byteData = word[8*offset +: 8];
    assign halfData = word[16*offset[1] +: 16]; // address bit 0 ignored for halves.

    // func3[1:0] picks the width, the lanes come from the low address bits.
    always_ff @(posedge clk)
    begin
        if (memWriteEnable)
        begin
            case (func3[1:0])
                2'b00:   mem[index][8*offset +: 8]     <= memWriteData[7:0];
                2'b01:   mem[index][16*offset[1] +: 16] <= memWriteData[15:0];
                default: mem[index] <= memWriteData;
            endcase
        end
    end

    always_comb
    begin
        case (func3)
            3'b000:  memReadData = {{24{byteData[7]}}, byteData};
            3'b001:  memReadData = {{16{halfData[15]}}, halfData};
            3'b100:  memReadData = {24'b0, byteData};
            3'b101:  memReadData = {16'b0, halfData};
            default: memReadData = word;
        endcase
    end

endmodule

//--- source/RegFile.sv
`timescale 1ns/100ps

module RegFile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [RiscvPkg::RegAddrWidth-1:0] readAddr1,
    input  logic [RiscvPkg::RegAddrWidth-1:0] readAddr2,
    output logic [RiscvPkg::DataWidth-1:0]    readData1,
    output logic [RiscvPkg::DataWidth-1:0]    readData2,
    input  logic                              writeEnable,
    input  logic [RiscvPkg::RegAddrWidth-1:0] writeAddr,
    input  logic [RiscvPkg::DataWidth-1:0]    writeData
);
    import RiscvPkg::*;

    logic [DataWidth-1:0] regs [2**RegAddrWidth];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 2**RegAddrWidth; i++)
                regs[i] <= '0;
        end
        else if (writeEnable && writeAddr != '0)
            regs[writeAddr] <= writeData; // x0 keeps its reset value.
    end

    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

//--- source/Alu.sv
`timescale 1ns/100ps

module Alu (
    input  RiscvPkg::aluOp_t               aluOp,
    input  logic [RiscvPkg::DataWidth-1:0] a,
    input  logic [RiscvPkg::DataWidth-1:0] b,
    output logic [RiscvPkg::DataWidth-1:0] aluO
);
    import RiscvPkg::*;

    logic [DataWidth-1:0] sum;
    logic [4:0]           shamt;

    assign sum   = a + b;
    assign shamt = b[4:0];

    always_comb
    begin
        case (aluOp)
            Add:        aluO = sum;
            Sub:        aluO = a - b;
            And:        aluO = a & b;
            Or:         aluO = a | b;
            Xor:        aluO = a ^ b;
            Sll:        aluO = a << shamt;
            Srl:        aluO = a >> shamt;
            Sra:        aluO = $signed(a) >>> shamt;
            Slt, Lt:    aluO = DataWidth'($signed(a) < $signed(b));
            Sltu, Ltu:  aluO = DataWidth'(a < b);
            Eq:         aluO = DataWidth'(a == b);
            Ne:         aluO = DataWidth'(a != b);
            Ge:         aluO = DataWidth'($signed(a) >= $signed(b));
            Geu:        aluO = DataWidth'(a >= b);
            JalrTarget: aluO = {sum[DataWidth-1:1], 1'b0};
            default:    aluO = '0;
        endcase
    end

endmodule

//--- source/InstrDecoder.sv
`timescale 1ns/100ps

module InstrDecoder (
    input  logic [RiscvPkg::DataWidth-1:0] instr,
    input  logic                           running,
    output RiscvPkg::decoded_t             decoded
);
    import RiscvPkg::*;

    opcode_t              opcode;
    logic [DataWidth-1:0] immI, immS, immB, immJ, immU;

    assign opcode = opcode_t'(instr[6:0]);
    assign immI   = {{20{instr[31]}}, instr[31:20]};
    assign immS   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign immU   = {instr[31:12], 12'b0};

    // shared by register and immediate forms. sub exists only with two registers.
    function automatic aluOp_t arithOp(input logic [2:0] f3, input logic alt, input logic isReg);
        case (f3)
            3'b000:  return (alt && isReg) ? Sub : Add;
            3'b001:  return Sll;
            3'b010:  return Slt;
            3'b011:  return Sltu;
            3'b100:  return Xor;
            3'b101:  return alt ? Sra : Srl;
            3'b110:  return Or;
            default: return And;
        endcase
    endfunction

    always_comb
    begin
        decoded.rs1    = instr[19:15];
        decoded.rs2    = instr[24:20];
        decoded.rd     = instr[11:7];
        decoded.func3  = instr[14:12];
        decoded.state  = Idle;
        decoded.aluOp  = Add;
        decoded.imm    = immI;
        decoded.useImm = 1'b0;
        case (opcode)
            OpReg:
            begin
                decoded.state = RegWrite;
                decoded.aluOp = arithOp(instr[14:12], instr[30], 1'b1);
            end
            OpImm:
            begin
                decoded.state  = RegWrite;
                decoded.aluOp  = arithOp(instr[14:12], instr[30], 1'b0);
                decoded.useImm = 1'b1;
            end
            OpLoad:
            begin
                decoded.state  = MemReadRegWrite;
                decoded.useImm = 1'b1; // address is rs1 plus offset.
            end
            OpStore:
            begin
                decoded.state  = MemWrite;
                decoded.imm    = immS;
                decoded.useImm = 1'b1;
            end
            OpBranch:
            begin
                decoded.state = PcSelectWrite;
                decoded.imm   = immB;
                case (instr[14:12])
                    3'b000:  decoded.aluOp = Eq;
                    3'b001:  decoded.aluOp = Ne;
                    3'b100:  decoded.aluOp = Lt;
                    3'b101:  decoded.aluOp = Ge;
                    3'b110:  decoded.aluOp = Ltu;
                    3'b111:  decoded.aluOp = Geu;
                    default: decoded.state = Idle;
                endcase
            end
            OpJal:
            begin
                decoded.state = PcWrite;
                decoded.imm   = immJ;
            end
            OpJalr:
            begin
                decoded.state  = PcWrite;
                decoded.aluOp  = JalrTarget;
                decoded.useImm = 1'b1;
            end
            OpLui:
            begin
                decoded.state = LuiRegWrite;
                decoded.imm   = immU;
            end
            OpSystem:
                if (instr == EbreakInstr)
                    decoded.state = Halt;
            default: ;
        endcase
        if (!running)
            decoded.state = Idle;
    end

endmodule

//--- source/InstrFetch.sv
`timescale 1ns/100ps

module InstrFetch (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    input  RiscvPkg::progWrite_t             progWrite,
    input  logic                             haltReq,
    input  logic                             pcWriteEnable,
    input  logic [RiscvPkg::DataWidth-1:0]   pcWriteData,
    output logic [RiscvPkg::AddrWidth-1:0]   pc,
    output logic [RiscvPkg::DataWidth-1:0]   instr,
    output logic                             running,
    output logic                             halted
);
    import RiscvPkg::*;

    logic [DataWidth-1:0] imem [ImemDepth];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running <= 1'b0;
            halted  <= 1'b0;
            pc      <= ResetPc;
        end
        else if (start)
        begin
            running <= 1'b1;
            halted  <= 1'b0;
            pc      <= ResetPc;
        end
        else if (running)
        begin
            if (haltReq)
            begin
                running <= 1'b0; // pc stays on the ebreak.
                halted  <= 1'b1;
            end
            else if (pcWriteEnable)
                pc <= pcWriteData;
            else
                pc <= pc + 4;
        end
    end

    // program load only while stopped.
    always_ff @(posedge clk)
    begin
        if (progWrite.valid && !running)
            imem[progWrite.addr] <= progWrite.data;
    end

    assign instr = imem[pc[ImemIndexWidth+1:2]];

endmodule

//--- source/RiscvPkg.sv
package RiscvPkg;

    localparam int DataWidth = 32;
    localparam int AddrWidth = 32;
    localparam int RegAddrWidth = 5;
    localparam int ImemDepth = 256;
    localparam int DmemDepth = 256;
    localparam int ImemIndexWidth = $clog2(ImemDepth);
    localparam int DmemIndexWidth = $clog2(DmemDepth);
    localparam logic [AddrWidth-1:0] ResetPc = '0;
    localparam logic [DataWidth-1:0] EbreakInstr = 32'h0010_0073;

    // operation class, one per instruction, consumed by the controller.
    typedef enum logic [2:0] {
        Idle,
        RegWrite,
        MemReadRegWrite,
        MemWrite,
        PcSelectWrite,
        PcWrite,
        LuiRegWrite,
        Halt
    } opState_t;

    typedef enum logic [4:0] {
        Add, Sub, And, Or, Xor,
        Slt, Sltu, Sll, Srl, Sra,
        Eq, Ne, Lt, Ge, Ltu, Geu,
        JalrTarget // add with bit 0 cleared.
    } aluOp_t;

    // major opcodes of the rv32i subset.
    typedef enum logic [6:0] {
        OpLoad   = 7'b0000011,
        OpImm    = 7'b0010011,
        OpStore  = 7'b0100011,
        OpReg    = 7'b0110011,
        OpLui    = 7'b0110111,
        OpBranch = 7'b1100011,
        OpJalr   = 7'b1100111,
        OpJal    = 7'b1101111,
        OpSystem = 7'b1110011
    } opcode_t;

    typedef struct packed {
        opState_t                state;
        aluOp_t                  aluOp;
        logic [RegAddrWidth-1:0] rs1;
        logic [RegAddrWidth-1:0] rs2;
        logic [RegAddrWidth-1:0] rd;
        logic [2:0]              func3;
        logic [DataWidth-1:0]    imm;
        logic                    useImm; // imm replaces rs2 as operand b.
    } decoded_t;

    typedef struct packed {
        logic                    valid;
        logic [AddrWidth-1:0]    pc;
        logic                    regWriteEnable;
        logic [RegAddrWidth-1:0] rd;
        logic [DataWidth-1:0]    regWriteData;
    } retire_t;

    typedef struct packed {
        logic                      valid;
        logic [ImemIndexWidth-1:0] addr; // word index.
        logic [DataWidth-1:0]      data;
    } progWrite_t;

endpackage
